//--- rtl/fetchPkg.sv
// shared fetch definitions: RV32I/RV64I base opcodes only, nop is addi x0,x0,0
`default_nettype none

package fetchPkg;

  ////////////////////////////////////////
  // constant words
  ////////////////////////////////////////

  // addi x0, x0, 0
  // flushes insert this and the instruction registers reset to it
  localparam logic [31:0] nopInstr = 32'h0000_0013;

  ////////////////////////////////////////
  // base opcodes used by the expander
  ////////////////////////////////////////

  // register-immediate alu ops
  localparam logic [6:0] opOpImm = 7'b001_0011;
  // loads
  localparam logic [6:0] opLoad  = 7'b000_0011;
  // stores
  localparam logic [6:0] opStore = 7'b010_0011;
  // register-register alu ops
  localparam logic [6:0] opOp    = 7'b011_0011;
  // jal
  localparam logic [6:0] opJal   = 7'b110_1111;

  ////////////////////////////////////////
  // one instruction word, two views
  ////////////////////////////////////////

  // base view follows the r-type field split
  // i, s and j immediates are packed across funct7, rs2, rs1, funct3 and rd
  // compressed view only means something in the low halfword
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } base;
    struct packed {
      // next halfword in memory, ignored for a 16-bit encoding
      logic [15:0] upper;
      logic [2:0]  funct3;
      // bits 12:2 of the halfword, layout depends on funct3 and op
      logic [10:0] mid;
      // quadrant, 2'b11 marks a 32-bit word
      logic [1:0]  op;
    } comp;
  } instrWord_u;

endpackage

`default_nettype wire

//--- rtl/fetchBus.sv
// PC-to-pipeline bundle; all four signals are driven by one source and read the same cycle
`default_nettype none

interface fetchBus #(
  parameter int xlen = 32
) ();

  // current fetch PC, always halfword aligned
  logic [xlen-1:0] pcF;
  // PC plus 2 or 4, later used as link address
  logic [xlen-1:0] pcPlusF;
  // level, taken E redirect to a misaligned target
  logic            branchMisalignedE;
  // selected next PC before bit 0 is cleared
  logic [xlen-1:0] misalignedAdrE;

  // PC logic side
  modport src (output pcF, output pcPlusF, output branchMisalignedE, output misalignedAdrE);

  // pipeline register side
  modport dst (input pcF, input pcPlusF, input branchMisalignedE, input misalignedAdrE);

endinterface

`default_nettype wire

//--- rtl/pcLogic.sv
// PC register and next-PC mux; redirects override stallF, no branch prediction or trap misalign fault
`default_nettype none

module pcLogic #(
  parameter int              xlen        = 32,
  parameter logic [xlen-1:0] resetVector = 'h8000_0000,
  parameter bit              cSupported  = 1'b1
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            stallF,
  input  logic            pcSrcE,
  input  logic            retM,
  input  logic            trapM,
  input  logic [xlen-1:0] pcTargetE,
  input  logic [xlen-1:0] privNextPcM,
  input  logic [31:0]     instrF,
  fetchBus.src            bus
);

  logic            privChangeM;
  logic            loadPc;
  logic            compressedF;
  logic [xlen-3:0] pcUpperPlus1;
  logic [xlen-1:0] pcPlus2or4;
  logic [xlen-1:0] unalignedNextF;
  logic [xlen-1:0] pcNextF;
  logic [xlen-1:0] pcReg;
  logic            misaligned;

  ////////////////////////////////////////
  // next PC selection
  ////////////////////////////////////////

  // ret or trap from the privileged unit
  assign privChangeM = retM | trapM;

  // privileged first, then E redirect, then sequential
  always_comb begin
    if (privChangeM) begin
      unalignedNextF = privNextPcM;
    end else if (pcSrcE) begin
      unalignedNextF = pcTargetE;
    end else begin
      unalignedNextF = pcPlus2or4;
    end
  end

  // instructions sit on halfword boundaries
  assign pcNextF = {unalignedNextF[xlen-1:1], 1'b0};

  // a redirect must land even while fetch is stalled
  assign loadPc = ~stallF | pcSrcE | privChangeM;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pcReg <= resetVector;
    end else if (loadPc) begin
      pcReg <= pcNextF;
    end
  end

  ////////////////////////////////////////
  // sequential increment
  ////////////////////////////////////////

  // low bits other than 2'b11 mean a 16-bit instruction
  assign compressedF  = (instrF[1:0] != 2'b11);
  // word increment of the upper bits
  assign pcUpperPlus1 = pcReg[xlen-1:2] + {{(xlen-3){1'b0}}, 1'b1};

  always_comb begin
    if (!compressedF) begin
      pcPlus2or4 = {pcUpperPlus1, pcReg[1:0]};
    end else if (pcReg[1]) begin
      // +2 from the upper halfword carries into the next word
      pcPlus2or4 = {pcUpperPlus1, 2'b00};
    end else begin
      pcPlus2or4 = {pcReg[xlen-1:2], 2'b10};
    end
  end

  ////////////////////////////////////////
  // misaligned target detection
  ////////////////////////////////////////

  // checked before bit 0 is cleared since an odd target is invisible afterwards
  if (cSupported) begin : gHalfAlign
    assign misaligned = unalignedNextF[0];
  end else begin : gWordAlign
    assign misaligned = |unalignedNextF[1:0];
  end

  assign bus.pcF               = pcReg;
  assign bus.pcPlusF           = pcPlus2or4;
  // only an E redirect raises it and the trap path is not covered
  assign bus.branchMisalignedE = misaligned & pcSrcE;
  assign bus.misalignedAdrE    = unalignedNextF;

  // the PC never holds an odd address
  pcAligned: assert property (@(posedge clk) disable iff (!rstN) !pcReg[0])
    else $error("pcF bit 0 set");

endmodule

`default_nettype wire

//--- rtl/decompress.sv
// RVC expander for C.ADDI4SPN/LW/SW/ADDI/LI/J/MV/ADD only; anything else becomes a flagged nop
`default_nettype none

module decompress #(
  parameter bit cSupported = 1'b1
) (
  input  fetchPkg::instrWord_u instrRaw,
  output fetchPkg::instrWord_u instrExp,
  output logic                 illegalComp
);

  import fetchPkg::*;

  localparam instrWord_u nopWord = nopInstr;

  logic [15:0] half;
  logic        isComp;
  logic [2:0]  rdP;
  logic [2:0]  rs1P;
  logic [11:0] immCi;
  logic [9:0]  nzuimm;
  logic [6:0]  uimmW;
  logic [11:1] offJ;
  instrWord_u  expanded;
  logic        unsupported;

  ////////////////////////////////////////
  // field extraction
  ////////////////////////////////////////

  // rebuild the halfword so bit numbers match the spec tables
  assign half   = {instrRaw.comp.funct3, instrRaw.comp.mid, instrRaw.comp.op};
  assign isComp = (instrRaw.comp.op != 2'b11);

  // 3-bit register fields that name x8 to x15
  assign rdP  = half[4:2];
  assign rs1P = half[9:7];

  // ci immediate sign extended to 12 bits
  assign immCi  = {{6{half[12]}}, half[12], half[6:2]};
  // addi4spn immediate scaled by 4 where zero is reserved
  assign nzuimm = {half[10:7], half[12:11], half[5], half[6], 2'b00};
  // lw/sw word offset
  assign uimmW  = {half[5], half[12:10], half[6], 2'b00};
  // cj jump offset above the always clear bit 0
  assign offJ   = {half[12], half[8], half[10:9], half[6], half[7], half[2], half[11],
                   half[5:3]};

  ////////////////////////////////////////
  // expansion table
  ////////////////////////////////////////

  always_comb begin
    expanded    = nopWord;
    unsupported = 1'b0;
    case ({instrRaw.comp.op, instrRaw.comp.funct3})
      5'b00_000: begin
        // c.addi4spn -> addi rd', x2, nzuimm
        {expanded.base.funct7, expanded.base.rs2} = {2'b00, nzuimm};
        expanded.base.rs1    = 5'd2;
        expanded.base.funct3 = 3'b000;
        expanded.base.rd     = {2'b01, rdP};
        expanded.base.opcode = opOpImm;
        // also catches the all-zero halfword
        unsupported          = (nzuimm == 10'd0);
      end
      5'b00_010: begin
        // c.lw -> lw rd', uimm(rs1')
        {expanded.base.funct7, expanded.base.rs2} = {5'd0, uimmW};
        expanded.base.rs1    = {2'b01, rs1P};
        expanded.base.funct3 = 3'b010;
        expanded.base.rd     = {2'b01, rdP};
        expanded.base.opcode = opLoad;
      end
      5'b00_110: begin
        // c.sw -> sw rs2', uimm(rs1'); s-type splits the offset
        expanded.base.funct7 = {5'd0, uimmW[6:5]};
        expanded.base.rs2    = {2'b01, rdP};
        expanded.base.rs1    = {2'b01, rs1P};
        expanded.base.funct3 = 3'b010;
        expanded.base.rd     = uimmW[4:0];
        expanded.base.opcode = opStore;
      end
      5'b01_000, 5'b01_010: begin
        // c.addi -> addi rd, rd, imm
        // c.li reads x0 instead of rd
        {expanded.base.funct7, expanded.base.rs2} = immCi;
        expanded.base.rs1    = instrRaw.comp.funct3[1] ? 5'd0 : half[11:7];
        expanded.base.funct3 = 3'b000;
        expanded.base.rd     = half[11:7];
        expanded.base.opcode = opOpImm;
      end
      5'b01_101: begin
        // c.j -> jal x0, offset; upper immediate bits are sign copies
        expanded.base.funct7 = {offJ[11], offJ[10:5]};
        expanded.base.rs2    = {offJ[4:1], offJ[11]};
        expanded.base.rs1    = {5{offJ[11]}};
        expanded.base.funct3 = {3{offJ[11]}};
        expanded.base.rd     = 5'd0;
        expanded.base.opcode = opJal;
      end
      5'b10_100: begin
        // rs2 of zero is c.jr/c.jalr/c.ebreak which are not handled here
        if (half[6:2] == 5'd0) begin
          unsupported = 1'b1;
        end else begin
          // c.mv -> add rd, x0, rs2 ; c.add -> add rd, rd, rs2
          expanded.base.funct7 = 7'd0;
          expanded.base.rs2    = half[6:2];
          expanded.base.rs1    = half[12] ? half[11:7] : 5'd0;
          expanded.base.funct3 = 3'b000;
          expanded.base.rd     = half[11:7];
          expanded.base.opcode = opOp;
        end
      end
      default: begin
        unsupported = 1'b1;
      end
    endcase
  end

  ////////////////////////////////////////
  // output select
  ////////////////////////////////////////

  if (cSupported) begin : gExpand
    // 32-bit words pass through untouched
    assign instrExp    = !isComp ? instrRaw : (unsupported ? nopWord : expanded);
    assign illegalComp = isComp & unsupported;
  end else begin : gBypass
    // without rvc every 16-bit encoding is illegal
    assign instrExp    = isComp ? nopWord : instrRaw;
    assign illegalComp = isComp;
  end

endmodule

`default_nettype wire

//--- rtl/fetchPipe.sv
// D/E/M/W fetch registers; only D stalls, E/M/W advance every cycle and react to flushes only
`default_nettype none

module fetchPipe #(
  parameter int xlen       = 32,
  parameter bit cSupported = 1'b1
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            stallD,
  input  logic            flushD,
  input  logic            flushE,
  input  logic            flushM,
  input  logic [31:0]     instrF,
  input  logic            illegalBaseD,
  fetchBus.dst            bus,
  output logic [31:0]     instrD,
  output logic [31:0]     instrM,
  output logic [xlen-1:0] pcE,
  output logic [xlen-1:0] pcM,
  output logic [xlen-1:0] pcLinkW,
  output logic            illegalInstrD,
  output logic            instrMisalignedFaultM,
  output logic [xlen-1:0] instrMisalignedAdrM
);

  import fetchPkg::*;

  localparam instrWord_u nopWord = nopInstr;

  instrWord_u      instrRawD;
  instrWord_u      instrExpD;
  instrWord_u      instrE;
  instrWord_u      instrMReg;
  logic            illegalCompD;
  logic [xlen-1:0] pcD;
  logic [xlen-1:0] pcLinkD;
  logic [xlen-1:0] pcLinkE;
  logic [xlen-1:0] pcLinkM;

  ////////////////////////////////////////
  // decode stage
  ////////////////////////////////////////

  // raw word captured from memory, flush only applies when not stalled
  always_ff @(posedge clk) begin
    if (!rstN) begin
      instrRawD <= nopWord;
    end else if (!stallD) begin
      instrRawD <= flushD ? nopWord : instrWord_u'(instrF);
    end
  end

  always_ff @(posedge clk) begin
    if (!stallD) begin
      pcD <= bus.pcF;
    end
  end

  // 16-bit words become their 32-bit form here
  decompress #(
    .cSupported (cSupported)
  ) decompress_i (
    .instrRaw    (instrRawD),
    .instrExp    (instrExpD),
    .illegalComp (illegalCompD)
  );

  // bad 16-bit or bad 32-bit encoding
  assign illegalInstrD = illegalCompD | illegalBaseD;
  assign instrD        = instrExpD;

  ////////////////////////////////////////
  // execute, memory, writeback
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      instrE    <= nopWord;
      instrMReg <= nopWord;
    end else begin
      instrE    <= flushE ? nopWord : instrExpD;
      instrMReg <= flushM ? nopWord : instrE;
    end
  end

  assign instrM = instrMReg;

  // pc and link address just shift along
  // link chain starts at F so pcLinkW trails pcPlusF by four edges
  always_ff @(posedge clk) begin
    pcE     <= pcD;
    pcM     <= pcE;
    pcLinkD <= bus.pcPlusF;
    pcLinkE <= pcLinkD;
    pcLinkM <= pcLinkE;
    pcLinkW <= pcLinkM;
  end

  // branch misalign fault moves from E into M
  always_ff @(posedge clk) begin
    if (!rstN) begin
      instrMisalignedFaultM <= 1'b0;
    end else begin
      instrMisalignedFaultM <= bus.branchMisalignedE;
    end
  end

  always_ff @(posedge clk) begin
    instrMisalignedAdrM <= bus.misalignedAdrE;
  end

  // a reported fault always carries an address that really is misaligned
  faultAdrMisaligned: assert property (@(posedge clk) disable iff (!rstN)
    instrMisalignedFaultM |->
      (cSupported ? instrMisalignedAdrM[0] : (|instrMisalignedAdrM[1:0])))
    else $error("misaligned fault with aligned address");

endmodule

`default_nettype wire

//--- rtl/fetchUnit.sv
// fetch unit top; instruction memory, decoder and privileged unit are outside, no handshakes
`default_nettype none

module fetchUnit #(
  parameter int              xlen        = 32,
  parameter logic [xlen-1:0] resetVector = 'h8000_0000,
  parameter bit              cSupported  = 1'b1
) (
  input  logic            clk,
  input  logic            rstN,
  // pipeline control levels
  input  logic            stallF,
  input  logic            stallD,
  input  logic            flushD,
  input  logic            flushE,
  input  logic            flushM,
  // redirects
  input  logic            pcSrcE,
  input  logic [xlen-1:0] pcTargetE,
  input  logic            retM,
  input  logic            trapM,
  input  logic [xlen-1:0] privNextPcM,
  // fetched word and decoder verdict
  input  logic [31:0]     instrF,
  input  logic            illegalBaseD,
  // stage outputs
  output logic [31:0]     instrD,
  output logic [31:0]     instrM,
  output logic [xlen-1:0] pcF,
  output logic [xlen-1:0] pcE,
  output logic [xlen-1:0] pcM,
  output logic [xlen-1:0] pcLinkW,
  output logic            illegalInstrD,
  output logic            instrMisalignedFaultM,
  output logic [xlen-1:0] instrMisalignedAdrM
);

  fetchBus #(.xlen(xlen)) bus_i ();

  // PC register, next-PC mux, misalign check
  pcLogic #(
    .xlen        (xlen),
    .resetVector (resetVector),
    .cSupported  (cSupported)
  ) pcLogic_i (
    .clk         (clk),
    .rstN        (rstN),
    .stallF      (stallF),
    .pcSrcE      (pcSrcE),
    .retM        (retM),
    .trapM       (trapM),
    .pcTargetE   (pcTargetE),
    .privNextPcM (privNextPcM),
    .instrF      (instrF),
    .bus         (bus_i.src)
  );

  // stage registers and expander
  fetchPipe #(
    .xlen       (xlen),
    .cSupported (cSupported)
  ) fetchPipe_i (
    .clk                   (clk),
    .rstN                  (rstN),
    .stallD                (stallD),
    .flushD                (flushD),
    .flushE                (flushE),
    .flushM                (flushM),
    .instrF                (instrF),
    .illegalBaseD          (illegalBaseD),
    .bus                   (bus_i.dst),
    .instrD                (instrD),
    .instrM                (instrM),
    .pcE                   (pcE),
    .pcM                   (pcM),
    .pcLinkW               (pcLinkW),
    .illegalInstrD         (illegalInstrD),
    .instrMisalignedFaultM (instrMisalignedFaultM),
    .instrMisalignedAdrM   (instrMisalignedAdrM)
  );

  assign pcF = bus_i.pcF;

endmodule

`default_nettype wire

//--- verif/fetchModel.svh
// fetch unit reference model for xlen 32 with compressed support; include inside the testbench module
`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

////////////////////////////////////////
// model state
////////////////////////////////////////

// copies of the PC and every stage register
logic [31:0] mPc;
logic [31:0] mRawD;
logic [31:0] mInstrE, mInstrM;
logic [31:0] mPcD, mPcE, mPcM;
logic [31:0] mLinkD, mLinkE, mLinkM, mLinkW;
logic        mFault;
logic [31:0] mFaultAdr;

////////////////////////////////////////
// expansion table
////////////////////////////////////////

// returns {illegal, 32-bit word} built straight from the RVC tables
function automatic logic [32:0] expandModel(input logic [31:0] w);
  logic [15:0] h;
  logic [4:0]  rdp;
  logic [4:0]  rs1p;
  logic [11:0] imm;
  logic [20:0] jOff;
  h    = w[15:0];
  rdp  = {2'b01, h[4:2]};
  rs1p = {2'b01, h[9:7]};
  // full-size word passes untouched
  if (h[1:0] == 2'b11) begin
    return {1'b0, w};
  end
  case ({h[1:0], h[15:13]})
    5'b00_000: begin
      // addi4spn where a zero immediate is reserved
      imm = {2'b00, h[10:7], h[12:11], h[5], h[6], 2'b00};
      if (imm == 12'd0) begin
        return {1'b1, nopInstr};
      end
      return {1'b0, imm, 5'd2, 3'b000, rdp, 7'h13};
    end
    5'b00_010: begin
      // lw
      imm = {5'd0, h[5], h[12:10], h[6], 2'b00};
      return {1'b0, imm, rs1p, 3'b010, rdp, 7'h03};
    end
    5'b00_110: begin
      // sw offset wraps the two registers
      imm = {5'd0, h[5], h[12:10], h[6], 2'b00};
      return {1'b0, imm[11:5], rdp, rs1p, 3'b010, imm[4:0], 7'h23};
    end
    5'b01_000, 5'b01_010: begin
      // addi or li with x0 as the li source
      imm = {{6{h[12]}}, h[12], h[6:2]};
      return {1'b0, imm, ((h[15:13] == 3'b010) ? 5'd0 : h[11:7]), 3'b000, h[11:7], 7'h13};
    end
    5'b01_101: begin
      // j as jal x0
      jOff = {{10{h[12]}}, h[8], h[10:9], h[6], h[7], h[2], h[11], h[5:3], 1'b0};
      return {1'b0, jOff[20], jOff[10:1], jOff[11], jOff[19:12], 5'd0, 7'h6f};
    end
    5'b10_100: begin
      // rs2 of x0 is jr/jalr/ebreak territory
      if (h[6:2] == 5'd0) begin
        return {1'b1, nopInstr};
      end
      return {1'b0, 7'd0, h[6:2], (h[12] ? h[11:7] : 5'd0), 3'b000, h[11:7], 7'h33};
    end
    default: return {1'b1, nopInstr};
  endcase
endfunction

////////////////////////////////////////
// one clock edge
////////////////////////////////////////

// uses the inputs that were stable before the edge
task automatic modelEdge();
  logic [31:0] plus;
  logic [31:0] nextPc;
  logic [32:0] expE;
  plus = mPc + ((instrF[1:0] == 2'b11) ? 32'd4 : 32'd2);
  if (retM || trapM) begin
    nextPc = privNextPcM;
  end else if (pcSrcE) begin
    nextPc = pcTargetE;
  end else begin
    nextPc = plus;
  end
  expE = expandModel(mRawD);
  // fault only under pcSrcE when the selected next PC is odd
  mFault    = rstN && pcSrcE && nextPc[0];
  mFaultAdr = nextPc;
  // link and pc chains shift from the back
  mLinkW = mLinkM;
  mLinkM = mLinkE;
  mLinkE = mLinkD;
  mLinkD = plus;
  mPcM   = mPcE;
  mPcE   = mPcD;
  if (!stallD) mPcD = mPc;
  if (!rstN) begin
    mRawD   = nopInstr;
    mInstrE = nopInstr;
    mInstrM = nopInstr;
    mPc     = resetVector;
  end else begin
    mInstrM = flushM ? nopInstr : mInstrE;
    mInstrE = flushE ? nopInstr : expE[31:0];
    if (!stallD) mRawD = flushD ? nopInstr : instrF;
    // redirects win over stallF
    if (!stallF || pcSrcE || retM || trapM) mPc = {nextPc[31:1], 1'b0};
  end
endtask

`endif

//--- verif/fetchUnitTb.sv
// random testbench for fetchUnit at xlen 32 with compressed support, LCG seed 4, 2000 cycles
`default_nettype none

module fetchUnitTb;

  import fetchPkg::*;

  localparam int          resetCycles   = 8;
  localparam int          numCycles     = 2000;
  localparam int          timeoutCycles = resetCycles + numCycles + 100;
  localparam logic [31:0] resetVector   = 32'h8000_0000;

  // DUT inputs
  logic        clk;
  logic        rstN;
  logic        stallF, stallD, flushD, flushE, flushM;
  logic        pcSrcE, retM, trapM;
  logic [31:0] pcTargetE;
  logic [31:0] privNextPcM;
  logic [31:0] instrF;
  logic        illegalBaseD;
  // DUT outputs
  logic [31:0] instrD, instrM;
  logic [31:0] pcF, pcE, pcM, pcLinkW;
  logic        illegalInstrD;
  logic        instrMisalignedFaultM;
  logic [31:0] instrMisalignedAdrM;

  logic [63:0] lcgState;
  int          errCount;
  int          checkCount;
  int          faultCount;

  `include "fetchModel.svh"

  fetchUnit #(
    .xlen        (32),
    .resetVector (resetVector),
    .cSupported  (1'b1)
  ) dut_i (
    .clk                   (clk),
    .rstN                  (rstN),
    .stallF                (stallF),
    .stallD                (stallD),
    .flushD                (flushD),
    .flushE                (flushE),
    .flushM                (flushM),
    .pcSrcE                (pcSrcE),
    .pcTargetE             (pcTargetE),
    .retM                  (retM),
    .trapM                 (trapM),
    .privNextPcM           (privNextPcM),
    .instrF                (instrF),
    .illegalBaseD          (illegalBaseD),
    .instrD                (instrD),
    .instrM                (instrM),
    .pcF                   (pcF),
    .pcE                   (pcE),
    .pcM                   (pcM),
    .pcLinkW               (pcLinkW),
    .illegalInstrD         (illegalInstrD),
    .instrMisalignedFaultM (instrMisalignedFaultM),
    .instrMisalignedAdrM   (instrMisalignedAdrM)
  );

  // 100 unit period
  initial clk = 1'b0;
  always #50 clk = ~clk;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // 64-bit LCG, upper half is the better one
  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 64'd6364136223846793005 + 64'd1442695040888963407;
    return lcgState[63:32];
  endfunction

  task automatic checkVal(input string name, input logic [31:0] expVal,
                          input logic [31:0] actVal);
    checkCount++;
    assert (actVal === expVal)
      else begin
        errCount++;
        $display("FAILED at %0t: %s expected %h actual %h", $time, name, expVal, actVal);
      end
  endtask

  task automatic driveInputs();
    logic [31:0] sel;
    logic [31:0] r;
    logic [4:0]  kind;
    // pick one supported {op, funct3}
    case (nextRand() % 7)
      0: kind = 5'b00_000;
      1: kind = 5'b00_010;
      2: kind = 5'b00_110;
      3: kind = 5'b01_000;
      4: kind = 5'b01_010;
      5: kind = 5'b01_101;
      default: kind = 5'b10_100;
    endcase
    sel = nextRand();
    r   = nextRand();
    // half supported compressed, then any 16-bit, zero halfword, 32-bit
    case (sel[31:29])
      3'd0, 3'd1, 3'd2, 3'd3: instrF = {r[31:16], kind[2:0], r[12:2], kind[4:3]};
      3'd4, 3'd5: instrF = {r[31:2], (r[1:0] == 2'b11) ? 2'b00 : r[1:0]};
      3'd6: instrF = {r[31:16], 16'h0000};
      default: instrF = {r[31:2], 2'b11};
    endcase
    // control levels, each one rare
    r            = nextRand();
    stallF       = (r[31:29] == 3'd0);
    stallD       = (r[28:26] == 3'd0);
    flushD       = (r[25:22] == 4'd0);
    flushE       = (r[21:18] == 4'd0);
    flushM       = (r[17:14] == 4'd0);
    pcSrcE       = (r[13:11] == 3'd0);
    retM         = (r[10:6] == 5'd0);
    trapM        = (r[5:1] == 5'd0);
    pcTargetE    = nextRand();
    privNextPcM  = nextRand();
    illegalBaseD = (nextRand() % 8) == 0;
  endtask

  task automatic compareOutputs();
    logic [32:0] expD;
    expD = expandModel(mRawD);
    checkVal("pcF", mPc, pcF);
    checkVal("instrD", expD[31:0], instrD);
    checkVal("illegalInstrD", expD[32] | illegalBaseD, illegalInstrD);
    checkVal("instrM", mInstrM, instrM);
    checkVal("pcE", mPcE, pcE);
    checkVal("pcM", mPcM, pcM);
    checkVal("pcLinkW", mLinkW, pcLinkW);
    checkVal("instrMisalignedFaultM", mFault, instrMisalignedFaultM);
    checkVal("instrMisalignedAdrM", mFaultAdr, instrMisalignedAdrM);
    if (mFault) faultCount++;
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin : mainSeq
    int cycle;
    lcgState     = 64'd4;
    errCount     = 0;
    checkCount   = 0;
    faultCount   = 0;
    rstN         = 1'b0;
    stallF       = 1'b0;
    stallD       = 1'b0;
    flushD       = 1'b0;
    flushE       = 1'b0;
    flushM       = 1'b0;
    pcSrcE       = 1'b0;
    retM         = 1'b0;
    trapM        = 1'b0;
    pcTargetE    = '0;
    privNextPcM  = '0;
    instrF       = nopInstr;
    illegalBaseD = 1'b0;
    for (cycle = 0; cycle < resetCycles + numCycles; cycle++) begin
      @(posedge clk);
      modelEdge();
      // drive just after the edge, check mid cycle
      #10;
      if (cycle == resetCycles - 1) rstN = 1'b1;
      if (cycle >= resetCycles - 1) driveInputs();
      #40;
      if (rstN) compareOutputs();
    end
    assert (faultCount > 0)
      else begin
        errCount++;
        $display("no misaligned branch fault was raised during the run");
      end
    $display("checks %0d errors %0d faults seen %0d", checkCount, errCount, faultCount);
    if (errCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // stops a run that never reaches its end
  initial begin : watchdog
    int waited;
    waited = 0;
    while (waited < timeoutCycles) begin
      @(posedge clk);
      waited++;
    end
    $display("timeout: run still active after %0d cycles", timeoutCycles);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+verif
rtl/fetchPkg.sv
rtl/fetchBus.sv
rtl/pcLogic.sv
rtl/decompress.sv
rtl/fetchPipe.sv
rtl/fetchUnit.sv
verif/fetchUnitTb.sv
